// File: run.sh
#!/bin/bash
# build and run the ejection stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -f verilog.f --top-module tb_local_eject

./obj_dir/Vtb_local_eject 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation finished without errors"

// File: src/eject_macros.svh
`ifndef EJECT_MACROS_SVH
`define EJECT_MACROS_SVH

// packet word and port count
`define EJ_DATA_W      64
`define EJ_NUM_PORTS   7
`define EJ_FIFO_DEPTH  4   // words per input buffer

// reduction packet fields
`define EJ_PAYLOAD_W   32
`define EJ_WEIGHT_W    8
`define EJ_IDX_W       4   // 16 table entries
`define EJ_CNT_W       3   // expect and arrival counts
`define EJ_ID_W        8

`endif

// File: src/eject_pkg.sv
`default_nettype none

`include "eject_macros.svh"

package eject_pkg;

    // one network word, decoded by the reduce flag
    // valid and reduce sit at the top of both views
    typedef union packed {
        struct packed {
            logic                     valid;
            logic                     reduce;
            logic [3:0]               exit_dir;  // exit request, not used at ejection
            logic [7:0]               prio;
            logic [17:0]              rsvd;
            logic [`EJ_PAYLOAD_W-1:0] payload;
        } plain;
        struct packed {
            logic                     valid;
            logic                     reduce;
            logic [`EJ_ID_W-1:0]      data_id;
            logic [`EJ_CNT_W-1:0]     expect_cnt;  // contributions in the group
            logic [`EJ_IDX_W-1:0]     index;       // reduction table slot
            logic [`EJ_WEIGHT_W-1:0]  weight;
            logic [6:0]               rsvd;
            logic [`EJ_PAYLOAD_W-1:0] payload;
        } red;
    } pkt_u;

endpackage

`default_nettype wire

// File: src/eject_switch.sv
`timescale 1ns/1ps
`default_nettype none

`include "eject_macros.svh"

// ejection crossbar: ordinary heads leave on their own port every cycle,
// flagged heads share one reduction path granted lowest port first
module eject_switch
    import eject_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  pkt_u [`EJ_NUM_PORTS-1:0]      heads,
    input  logic [`EJ_NUM_PORTS-1:0]      empty,
    output logic [`EJ_NUM_PORTS-1:0]      pop,
    output pkt_u [`EJ_NUM_PORTS-1:0]      outs,
    reduce_if.src                         red
);

    localparam int NP = `EJ_NUM_PORTS;

    logic [NP-1:0] ord_req;   // head present and ordinary
    logic [NP-1:0] red_req;   // head present and wants the reduction path
    logic [NP-1:0] grant;
    pkt_u          sel;       // granted head

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            ord_req[p] = ~empty[p] & ~heads[p].plain.reduce;
            red_req[p] = ~empty[p] & heads[p].red.reduce;
        end
    end

    // isolate the lowest set request bit
    assign grant = red_req & (~red_req + NP'(1));

    assign pop = ord_req | grant;

    always_comb begin
        sel = '0;
        for (int p = 0; p < NP; p++) begin
            if (grant[p]) begin
                sel = heads[p];
            end
        end
    end

    // port outputs hold a word for exactly one cycle after its pop
    always_ff @(posedge clk) begin
        if (rst) begin
            outs <= '0;
        end else begin
            for (int p = 0; p < NP; p++) begin
                outs[p] <= ord_req[p] ? heads[p] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            red.valid <= 1'b0;
        end else begin
            red.valid <= |grant;
        end
    end

    // contribution fields follow the strobe
    always_ff @(posedge clk) begin
        red.data_id    <= sel.red.data_id;
        red.expect_cnt <= sel.red.expect_cnt;
        red.index      <= sel.red.index;
        red.weight     <= sel.red.weight;
        red.payload    <= sel.red.payload;
    end

    // only one flagged head may leave its buffer per cycle
    a_one_red_pop: assert property (@(posedge clk) disable iff (rst)
        $onehot0(pop & red_req))
        else $error("eject_switch: more than one reduction head popped");

endmodule

`default_nettype wire

// File: src/local_eject.sv
`timescale 1ns/1ps
`default_nettype none

`include "eject_macros.svh"

// ejection stage of a 3D-torus node
// port order local, yneg, ypos, xpos, xneg, zpos, zneg
module local_eject
    import eject_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`EJ_DATA_W-1:0] in_local,
    input  logic [`EJ_DATA_W-1:0] in_yneg,
    input  logic [`EJ_DATA_W-1:0] in_ypos,
    input  logic [`EJ_DATA_W-1:0] in_xpos,
    input  logic [`EJ_DATA_W-1:0] in_xneg,
    input  logic [`EJ_DATA_W-1:0] in_zpos,
    input  logic [`EJ_DATA_W-1:0] in_zneg,
    input  logic                  in_stall_local,
    input  logic                  in_stall_yneg,
    input  logic                  in_stall_ypos,
    input  logic                  in_stall_xpos,
    input  logic                  in_stall_xneg,
    input  logic                  in_stall_zpos,
    input  logic                  in_stall_zneg,
    output logic                  in_avail_local,
    output logic                  in_avail_yneg,
    output logic                  in_avail_ypos,
    output logic                  in_avail_xpos,
    output logic                  in_avail_xneg,
    output logic                  in_avail_zpos,
    output logic                  in_avail_zneg,
    output logic [`EJ_DATA_W-1:0] out_local,
    output logic [`EJ_DATA_W-1:0] out_yneg,
    output logic [`EJ_DATA_W-1:0] out_ypos,
    output logic [`EJ_DATA_W-1:0] out_xpos,
    output logic [`EJ_DATA_W-1:0] out_xneg,
    output logic [`EJ_DATA_W-1:0] out_zpos,
    output logic [`EJ_DATA_W-1:0] out_zneg,
    output logic                  local_send,
    output logic                  yneg_send,
    output logic                  ypos_send,
    output logic                  xpos_send,
    output logic                  xneg_send,
    output logic                  zpos_send,
    output logic                  zneg_send,
    output logic [`EJ_DATA_W-1:0] out_reduction
);

    pkt_u [`EJ_NUM_PORTS-1:0] din;
    pkt_u [`EJ_NUM_PORTS-1:0] heads;
    pkt_u [`EJ_NUM_PORTS-1:0] outs;
    logic [`EJ_NUM_PORTS-1:0] stall;
    logic [`EJ_NUM_PORTS-1:0] full;
    logic [`EJ_NUM_PORTS-1:0] empty;
    logic [`EJ_NUM_PORTS-1:0] pop;

    reduce_if red ();

    assign din   = {in_zneg, in_zpos, in_xneg, in_xpos, in_ypos, in_yneg, in_local};
    assign stall = {in_stall_zneg, in_stall_zpos, in_stall_xneg, in_stall_xpos,
                    in_stall_ypos, in_stall_yneg, in_stall_local};

    assign {in_avail_zneg, in_avail_zpos, in_avail_xneg, in_avail_xpos,
            in_avail_ypos, in_avail_yneg, in_avail_local} = ~full;

    assign {out_zneg, out_zpos, out_xneg, out_xpos, out_ypos, out_yneg, out_local} = outs;

    // send strobe is the valid bit of each port word
    assign local_send = outs[0].plain.valid;
    assign yneg_send  = outs[1].plain.valid;
    assign ypos_send  = outs[2].plain.valid;
    assign xpos_send  = outs[3].plain.valid;
    assign xneg_send  = outs[4].plain.valid;
    assign zpos_send  = outs[5].plain.valid;
    assign zneg_send  = outs[6].plain.valid;

    for (genvar p = 0; p < `EJ_NUM_PORTS; p++) begin : g_fifo
        port_fifo #(
            .DEPTH (`EJ_FIFO_DEPTH)
        ) u_port_fifo (
            .clk   (clk),
            .rst   (rst),
            .din   (din[p]),
            .stall (stall[p]),
            .pop   (pop[p]),
            .head  (heads[p]),
            .empty (empty[p]),
            .full  (full[p])
        );
    end

    eject_switch u_eject_switch (
        .clk   (clk),
        .rst   (rst),
        .heads (heads),
        .empty (empty),
        .pop   (pop),
        .outs  (outs),
        .red   (red.src)
    );

    reduce_unit u_reduce_unit (
        .clk           (clk),
        .rst           (rst),
        .red           (red.sink),
        .out_reduction (out_reduction)
    );

endmodule

`default_nettype wire

// File: src/port_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "eject_macros.svh"

// input buffer for one direction, head is visible without a read cycle
module port_fifo
    import eject_pkg::*;
#(
    parameter int DEPTH = `EJ_FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  pkt_u din,
    input  logic stall,
    input  logic pop,
    output pkt_u head,
    output logic empty,
    output logic full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    pkt_u             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;

    assign wr_en = din.plain.valid & ~stall;  // upstream keeps the old rule

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or write plus pop
            endcase
        end
    end

    // upstream must honour in_avail and the switch must only pop a present head
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(wr_en && full))
        else $error("port_fifo: write into full buffer");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty))
        else $error("port_fifo: pop from empty buffer");

endmodule

`default_nettype wire

// File: src/reduce_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "eject_macros.svh"

// one granted reduction contribution per cycle, no back-pressure
interface reduce_if;
    logic                     valid;  // single-cycle strobe
    logic [`EJ_ID_W-1:0]      data_id;
    logic [`EJ_CNT_W-1:0]     expect_cnt;
    logic [`EJ_IDX_W-1:0]     index;
    logic [`EJ_WEIGHT_W-1:0]  weight;
    logic [`EJ_PAYLOAD_W-1:0] payload;

    modport src (
        output valid, data_id, expect_cnt, index, weight, payload
    );

    modport sink (
        input valid, data_id, expect_cnt, index, weight, payload
    );
endinterface

`default_nettype wire

// File: src/reduce_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "eject_macros.svh"

// reduction table with a two-stage read-modify-write
// stage one reads the slot, stage two accumulates and writes back or emits
module reduce_unit
    import eject_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    reduce_if.sink red,
    output pkt_u   out_reduction
);

    localparam int ENTRIES = 1 << `EJ_IDX_W;

    logic [`EJ_CNT_W-1:0]     tbl_cnt [ENTRIES];  // arrivals so far
    logic [`EJ_WEIGHT_W-1:0]  tbl_w   [ENTRIES];
    logic [`EJ_PAYLOAD_W-1:0] tbl_p   [ENTRIES];

    // stage one registers, the contribution plus the entry it hits
    logic                     s1_valid;
    logic [`EJ_ID_W-1:0]      s1_id;
    logic [`EJ_CNT_W-1:0]     s1_expect;
    logic [`EJ_IDX_W-1:0]     s1_index;
    logic [`EJ_WEIGHT_W-1:0]  s1_weight;
    logic [`EJ_PAYLOAD_W-1:0] s1_payload;
    logic [`EJ_CNT_W-1:0]     s1_cnt;
    logic [`EJ_WEIGHT_W-1:0]  s1_wsum;
    logic [`EJ_PAYLOAD_W-1:0] s1_psum;

    // stage two results
    logic [`EJ_CNT_W-1:0]     nxt_cnt;
    logic [`EJ_WEIGHT_W-1:0]  nxt_w;
    logic [`EJ_PAYLOAD_W-1:0] nxt_p;
    logic                     done;
    logic [`EJ_CNT_W-1:0]     wb_cnt;
    logic [`EJ_WEIGHT_W-1:0]  wb_w;
    logic [`EJ_PAYLOAD_W-1:0] wb_p;
    logic                     fwd;
    pkt_u                     res;

    assign nxt_cnt = s1_cnt + 1'b1;
    assign nxt_w   = s1_wsum + s1_weight;   // wraps mod 256
    assign nxt_p   = s1_psum + s1_payload;
    assign done    = s1_valid && (nxt_cnt == s1_expect);

    // completed group leaves a cleared slot behind
    assign wb_cnt = done ? '0 : nxt_cnt;
    assign wb_w   = done ? '0 : nxt_w;
    assign wb_p   = done ? '0 : nxt_p;

    // same slot being written this edge, the table copy would be stale
    assign fwd = s1_valid && (red.index == s1_index);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= red.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_id      <= red.data_id;
        s1_expect  <= red.expect_cnt;
        s1_index   <= red.index;
        s1_weight  <= red.weight;
        s1_payload <= red.payload;
        if (fwd) begin
            s1_cnt  <= wb_cnt;
            s1_wsum <= wb_w;
            s1_psum <= wb_p;
        end else begin
            s1_cnt  <= tbl_cnt[red.index];
            s1_wsum <= tbl_w[red.index];
            s1_psum <= tbl_p[red.index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                tbl_cnt[i] <= '0;
                tbl_w[i]   <= '0;
                tbl_p[i]   <= '0;
            end
        end else if (s1_valid) begin
            tbl_cnt[s1_index] <= wb_cnt;
            tbl_w[s1_index]   <= wb_w;
            tbl_p[s1_index]   <= wb_p;
        end
    end

    // combined packet keeps the last contributor's id
    always_comb begin
        res                = '0;
        res.red.valid      = 1'b1;
        res.red.reduce     = 1'b1;
        res.red.data_id    = s1_id;
        res.red.expect_cnt = s1_expect;
        res.red.index      = s1_index;
        res.red.weight     = nxt_w;
        res.red.payload    = nxt_p;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_reduction <= '0;
        end else begin
            out_reduction <= done ? res : '0;
        end
    end

    // an expect count of zero would never complete and leak the slot
    a_expect_nonzero: assert property (@(posedge clk) disable iff (rst)
        red.valid |-> (red.expect_cnt != '0))
        else $error("reduce_unit: contribution with zero expect count");

endmodule

`default_nettype wire

// File: verif/tb_local_eject.sv
`timescale 1ns/1ps
`default_nettype none

`include "eject_macros.svh"

module tb_local_eject
    import eject_pkg::*;
();

    localparam int NP      = `EJ_NUM_PORTS;
    localparam int DEPTH   = `EJ_FIFO_DEPTH;
    localparam int ENTRIES = 1 << `EJ_IDX_W;
    // about 150 cycles of tests, generous margin for the draining loops
    localparam int TIMEOUT = 2000;

    logic                              clk = 1'b0;
    logic                              rst;
    logic [NP-1:0][`EJ_DATA_W-1:0]     in_w;
    logic [NP-1:0]                     stall_v;
    wire  [NP-1:0]                     avail_v;
    wire  [NP-1:0][`EJ_DATA_W-1:0]     out_w;
    wire  [NP-1:0]                     send_v;
    wire  [`EJ_DATA_W-1:0]             out_red;

    // reference model state
    logic [`EJ_DATA_W-1:0]    mq [NP][$];   // expected buffer contents per port
    logic [`EJ_WEIGHT_W-1:0]  m_wsum [ENTRIES];
    logic [`EJ_PAYLOAD_W-1:0] m_psum [ENTRIES];
    int                       m_cnt [ENTRIES];
    logic [`EJ_DATA_W-1:0]    exp_out [NP];
    logic [NP-1:0]            exp_avail;
    logic [`EJ_DATA_W-1:0]    stage_a;      // strobe on reduce_if
    logic [`EJ_DATA_W-1:0]    stage_b;      // table read stage
    logic [`EJ_DATA_W-1:0]    exp_red;

    int     errors = 0;
    int     cycles = 0;
    string  test_name = "reset";
    integer seed = 32'hdea535b9;

    always #50 clk = ~clk;

    local_eject u_local_eject (
        .clk            (clk),
        .rst            (rst),
        .in_local       (in_w[0]),
        .in_yneg        (in_w[1]),
        .in_ypos        (in_w[2]),
        .in_xpos        (in_w[3]),
        .in_xneg        (in_w[4]),
        .in_zpos        (in_w[5]),
        .in_zneg        (in_w[6]),
        .in_stall_local (stall_v[0]),
        .in_stall_yneg  (stall_v[1]),
        .in_stall_ypos  (stall_v[2]),
        .in_stall_xpos  (stall_v[3]),
        .in_stall_xneg  (stall_v[4]),
        .in_stall_zpos  (stall_v[5]),
        .in_stall_zneg  (stall_v[6]),
        .in_avail_local (avail_v[0]),
        .in_avail_yneg  (avail_v[1]),
        .in_avail_ypos  (avail_v[2]),
        .in_avail_xpos  (avail_v[3]),
        .in_avail_xneg  (avail_v[4]),
        .in_avail_zpos  (avail_v[5]),
        .in_avail_zneg  (avail_v[6]),
        .out_local      (out_w[0]),
        .out_yneg       (out_w[1]),
        .out_ypos       (out_w[2]),
        .out_xpos       (out_w[3]),
        .out_xneg       (out_w[4]),
        .out_zpos       (out_w[5]),
        .out_zneg       (out_w[6]),
        .local_send     (send_v[0]),
        .yneg_send      (send_v[1]),
        .ypos_send      (send_v[2]),
        .xpos_send      (send_v[3]),
        .xneg_send      (send_v[4]),
        .zpos_send      (send_v[5]),
        .zneg_send      (send_v[6]),
        .out_reduction  (out_red)
    );

    // transaction model: ordinary heads leave next edge, one flagged head per edge,
    // lowest port first, combined word two edges after the grant
    always @(posedge clk) begin : ref_model
        pkt_u h;
        pkt_u w;
        pkt_u cmp;
        logic granted;
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                m_wsum[i] = '0;
                m_psum[i] = '0;
                m_cnt[i]  = 0;
            end
            for (int p = 0; p < NP; p++) begin
                mq[p].delete();
                exp_out[p] <= '0;
            end
            exp_avail <= '1;
            stage_a   <= '0;
            stage_b   <= '0;
            exp_red   <= '0;
        end else begin
            granted = 1'b0;
            cmp     = '0;
            for (int p = 0; p < NP; p++) begin
                exp_out[p] <= '0;
                if (mq[p].size() > 0) begin
                    h = mq[p][0];
                    if (!h.plain.reduce) begin
                        exp_out[p] <= h;
                        mq[p].delete(0);
                    end else if (!granted) begin
                        granted = 1'b1;
                        mq[p].delete(0);
                        m_wsum[h.red.index] += h.red.weight;   // wraps mod 256
                        m_psum[h.red.index] += h.red.payload;
                        m_cnt[h.red.index]++;
                        if (m_cnt[h.red.index] == int'(h.red.expect_cnt)) begin
                            cmp.red.valid      = 1'b1;
                            cmp.red.reduce     = 1'b1;
                            cmp.red.data_id    = h.red.data_id;
                            cmp.red.expect_cnt = h.red.expect_cnt;
                            cmp.red.index      = h.red.index;
                            cmp.red.weight     = m_wsum[h.red.index];
                            cmp.red.payload    = m_psum[h.red.index];
                            m_wsum[h.red.index] = '0;   // slot free for reuse
                            m_psum[h.red.index] = '0;
                            m_cnt[h.red.index]  = 0;
                        end
                    end
                end
            end
            for (int p = 0; p < NP; p++) begin
                w = in_w[p];
                if (w.plain.valid && !stall_v[p]) begin
                    mq[p].push_back(w);
                end
                exp_avail[p] <= (mq[p].size() < DEPTH);
            end
            stage_a <= cmp;
            stage_b <= stage_a;
            exp_red <= stage_b;
        end
    end

    for (genvar p = 0; p < NP; p++) begin : g_check
        a_port_word: assert property (@(posedge clk) disable iff (rst)
            out_w[p] == exp_out[p])
            else begin
                errors++;
                $display("[FAIL] %s: port %0d word expected %h actual %h", test_name, p,
                         $sampled(exp_out[p]), $sampled(out_w[p]));
            end

        a_send: assert property (@(posedge clk) disable iff (rst)
            send_v[p] == exp_out[p][`EJ_DATA_W-1])
            else begin
                errors++;
                $display("[FAIL] %s: port %0d send expected %b actual %b", test_name, p,
                         $sampled(exp_out[p][`EJ_DATA_W-1]), $sampled(send_v[p]));
            end

        a_avail: assert property (@(posedge clk) disable iff (rst)
            avail_v[p] == exp_avail[p])
            else begin
                errors++;
                $display("[FAIL] %s: port %0d in_avail expected %b actual %b", test_name, p,
                         $sampled(exp_avail[p]), $sampled(avail_v[p]));
            end
    end

    a_reduction: assert property (@(posedge clk) disable iff (rst)
        out_red == exp_red)
        else begin
            errors++;
            $display("[FAIL] %s: out_reduction expected %h actual %h", test_name,
                     $sampled(exp_red), $sampled(out_red));
        end

    // send, out_reduction and in_avail shown as one concatenated word
    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (send_v == '0 && out_red == '0 && &avail_v))
        else begin
            errors++;
            $display("[FAIL] %s: send red avail expected %h actual %h",
                     test_name, {{NP{1'b0}}, {`EJ_DATA_W{1'b0}}, {NP{1'b1}}},
                     {$sampled(send_v), $sampled(out_red), $sampled(avail_v)});
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic clear_inputs();
        in_w    = '0;
        stall_v = '0;
    endtask

    function automatic logic [`EJ_DATA_W-1:0] make_plain();
        pkt_u w;
        w = {$random(seed), $random(seed)};
        w.plain.valid  = 1'b1;
        w.plain.reduce = 1'b0;
        return w;
    endfunction

    // weight and payload stay random
    function automatic logic [`EJ_DATA_W-1:0] make_red(input logic [`EJ_IDX_W-1:0] idx,
                                                       input logic [`EJ_CNT_W-1:0] cnt);
        pkt_u w;
        w = {$random(seed), $random(seed)};
        w.red.valid      = 1'b1;
        w.red.reduce     = 1'b1;
        w.red.expect_cnt = cnt;
        w.red.index      = idx;
        return w;
    endfunction

    function automatic logic model_idle();
        for (int p = 0; p < NP; p++) begin
            if (mq[p].size() != 0 || exp_out[p] != '0) begin
                return 1'b0;
            end
        end
        return (stage_a == '0 && stage_b == '0 && exp_red == '0);
    endfunction

    task automatic wait_idle();
        @(negedge clk);
        clear_inputs();
        while (!model_idle()) begin
            @(negedge clk);
        end
    endtask

    // one contribution, held back while the port buffer is full
    task automatic send_red(input int p, input logic [`EJ_DATA_W-1:0] w);
        @(negedge clk);
        clear_inputs();
        while (!avail_v[p]) begin
            @(negedge clk);
        end
        in_w[p] = w;
    endtask

    initial begin
        logic [NP-1:0]        mask;
        logic [`EJ_IDX_W-1:0] idx_a;
        logic [`EJ_IDX_W-1:0] idx_b;
        int                   port;
        rst = 1'b1;
        clear_inputs();
        repeat (2) @(negedge clk);
        rst = 1'b0;

        test_name = "pass_through";
        for (int k = 0; k < 24; k++) begin
            @(negedge clk);
            clear_inputs();
            mask = (k >= 20) ? '1 : NP'($random(seed));   // last cycles load every port
            for (int p = 0; p < NP; p++) begin
                if (mask[p] && avail_v[p]) begin
                    in_w[p] = make_plain();
                end
            end
        end
        wait_idle();

        test_name = "stall_gating";
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            clear_inputs();
            for (int p = 0; p < NP; p++) begin
                in_w[p] = make_plain();
                if ($random(seed) & 1) begin
                    stall_v[p] = 1'b1;
                end else begin
                    in_w[p][`EJ_DATA_W-1] = 1'b0;   // valid clear
                end
            end
        end
        wait_idle();

        test_name = "reduce_group";
        for (int n = 1; n <= NP; n++) begin
            idx_a = `EJ_IDX_W'($random(seed));
            for (int k = 0; k < n; k++) begin
                port = $unsigned($random(seed)) % NP;
                send_red(port, make_red(idx_a, `EJ_CNT_W'(n)));
            end
            wait_idle();
        end

        // grant order a a b a b a, then the freed slot a twice
        test_name = "forward_reuse";
        idx_a = `EJ_IDX_W'($random(seed));
        idx_b = idx_a ^ `EJ_IDX_W'(5);
        @(negedge clk);
        clear_inputs();
        in_w[0] = make_red(idx_a, 3'd4);   // ports 0 and 1 granted on consecutive edges
        in_w[1] = make_red(idx_a, 3'd4);
        in_w[2] = make_red(idx_b, 3'd2);
        @(negedge clk);
        clear_inputs();
        in_w[3] = make_red(idx_a, 3'd4);
        in_w[4] = make_red(idx_b, 3'd2);
        in_w[5] = make_red(idx_a, 3'd4);
        in_w[6] = make_red(idx_a, 3'd2);   // first word of the reused slot
        @(negedge clk);
        clear_inputs();
        in_w[6] = make_red(idx_a, 3'd2);
        wait_idle();

        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/eject_pkg.sv
src/reduce_if.sv
src/port_fifo.sv
src/eject_switch.sv
src/reduce_unit.sv
src/local_eject.sv
verif/tb_local_eject.sv
